// ==== Makefile ====
TOOL     := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := tb_dma_read
FILELIST := sources.f

OBJ_DIR  := obj_dir
LOG      := sim.log
FAIL_MSG := Some tests failed
PASS_MSG := All tests passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(TOOL), run $(TOP), log to $(LOG)"
	@echo "  clean  remove build output and log"
	@echo "  help   list these targets"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== design/dma_read_fifo.sv ====
`timescale 1ns/1ps

module dma_read_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  PTR_BITS  = 2
) (
    input  logic     rst,
    input  logic     s_axi4l,
    input  payload_t s_data,
    input  logic     s_valid,
    output logic     s_ready,
    output payload_t m_data,
    output logic     m_valid,
    input  logic     m_ready
);

    localparam int DEPTH = 2 ** PTR_BITS;

    payload_t            mem [DEPTH];
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [PTR_BITS:0]   count;
    logic                full;
    logic                push;
    logic                pop;

    assign full    = count == (PTR_BITS + 1)'(DEPTH);
    assign s_ready = ~full;
    assign push    = s_valid & s_ready;
    assign pop     = m_valid & m_ready;

    // head word is read straight from the storage flops
    assign m_valid = count != '0;
    assign m_data  = mem[rd_ptr];

    always_ff @(posedge s_axi4l) begin
        if (push) begin
            mem[wr_ptr] <= s_data;
        end
    end

    always_ff @(posedge s_axi4l) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + PTR_BITS'(1);
            end
            if (pop) begin
                rd_ptr <= rd_ptr + PTR_BITS'(1);
            end
            case ({push, pop})
                2'b10:   count <= count + (PTR_BITS + 1)'(1);
                2'b01:   count <= count - (PTR_BITS + 1)'(1);
                default: ;
            endcase
        end
    end

    // ------------------------------------------------
    // checks
    // ------------------------------------------------
    // a write never lands on an unread word
    a_no_write_full: assert property (
        @(posedge s_axi4l) disable iff (rst)
        push |-> count == '0 || wr_ptr != rd_ptr
    ) else $error("fifo written while full");

endmodule

// ==== design/dma_read_issue.sv ====
`timescale 1ns/1ps

module dma_read_issue #(
    parameter int CMD_PTR_BITS = 2
) (
    input  logic                  s_axi4l,
    input  logic                  rst,
    input  dma_read_pkg::ar_cmd_t cmd,
    input  logic                  cmd_valid,
    output logic                  cmd_ready,
    output dma_read_pkg::ar_cmd_t ar,
    output logic                  arvalid,
    input  logic                  arready,
    input  logic                  beat_done,
    output logic                  busy
);

    import dma_read_pkg::*;

    // room for many full-length bursts in flight
    localparam int CNT_BITS = 16;

    logic                ar_hs;
    logic [CNT_BITS-1:0] burst_beats;
    logic [CNT_BITS-1:0] open_beats;

    dma_read_fifo #(
        .payload_t (ar_cmd_t),
        .PTR_BITS  (CMD_PTR_BITS)
    ) cmd_fifo_i (
        .rst     (rst),
        .s_axi4l (s_axi4l),
        .s_data  (cmd),
        .s_valid (cmd_valid),
        .s_ready (cmd_ready),
        .m_data  (ar),
        .m_valid (arvalid),
        .m_ready (arready)
    );

    // ------------------------------------------------
    // requested but undelivered beats
    // ------------------------------------------------
    assign ar_hs       = arvalid & arready;
    assign burst_beats = CNT_BITS'(ar.len) + CNT_BITS'(1);

    always_ff @(posedge s_axi4l) begin
        if (rst) begin
            open_beats <= '0;
        end else begin
            open_beats <= open_beats + (ar_hs ? burst_beats : '0) - CNT_BITS'(beat_done);
        end
    end

    assign busy = arvalid | (open_beats != '0);

    a_ar_stable: assert property (
        @(posedge s_axi4l) disable iff (rst)
        arvalid && !arready |=> arvalid && $stable(ar)
    ) else $error("read address changed while stalled");

    // a delivered beat was always requested earlier
    a_no_underflow: assert property (
        @(posedge s_axi4l) disable iff (rst)
        beat_done |-> open_beats != '0
    ) else $error("beat delivered with no open request");

endmodule

// ==== design/dma_read_pkg.sv ====
package dma_read_pkg;

    // ------------------------------------------------
    // sizes
    // ------------------------------------------------
    localparam int AXIL_ADDR_BITS = 32;
    localparam int AXIL_DATA_BITS = 32;
    localparam int AXIL_STRB_BITS = AXIL_DATA_BITS / 8;
    localparam int DATA_BITS      = 64;

    typedef logic [AXIL_ADDR_BITS-1:0] axil_addr_t;
    typedef logic [AXIL_DATA_BITS-1:0] axil_data_t;
    typedef logic [AXIL_STRB_BITS-1:0] axil_strb_t;
    typedef logic [AXIL_ADDR_BITS-3:0] reg_idx_t;
    typedef logic [DATA_BITS-1:0]      data_t;

    // read-address field types
    typedef logic [7:0]  id_t;
    typedef logic [31:0] addr_t;
    typedef logic [7:0]  len_t;
    typedef logic [2:0]  size_t;
    typedef logic [1:0]  burst_t;
    typedef logic [0:0]  lock_t;
    typedef logic [3:0]  cache_t;
    typedef logic [2:0]  prot_t;
    typedef logic [3:0]  qos_t;
    typedef logic [3:0]  region_t;

    // ------------------------------------------------
    // register map, word indices
    // ------------------------------------------------
    localparam reg_idx_t REG_CORE_ID          = reg_idx_t'('h00);
    localparam reg_idx_t REG_CTL_STATUS       = reg_idx_t'('h08);
    localparam reg_idx_t REG_PARAM_ARID       = reg_idx_t'('h10);
    localparam reg_idx_t REG_PARAM_ARADDR     = reg_idx_t'('h11);
    localparam reg_idx_t REG_PARAM_ARLEN      = reg_idx_t'('h12);
    localparam reg_idx_t REG_PARAM_ARSIZE     = reg_idx_t'('h13);
    localparam reg_idx_t REG_PARAM_ARBURST    = reg_idx_t'('h14);
    localparam reg_idx_t REG_PARAM_ARLOCK     = reg_idx_t'('h15);
    localparam reg_idx_t REG_PARAM_ARCACHE    = reg_idx_t'('h16);
    localparam reg_idx_t REG_PARAM_ARPROT     = reg_idx_t'('h17);
    localparam reg_idx_t REG_PARAM_ARQOS      = reg_idx_t'('h18);
    localparam reg_idx_t REG_PARAM_ARREGION   = reg_idx_t'('h19);

    localparam axil_data_t CORE_ID = 32'haa55_0002;

    // ------------------------------------------------
    // bundles
    // ------------------------------------------------
    typedef struct packed {
        id_t     id;
        addr_t   addr;
        len_t    len;
        size_t   size;
        burst_t  burst;
        lock_t   lock;
        cache_t  cache;
        prot_t   prot;
        qos_t    qos;
        region_t region;
    } ar_cmd_t;

    // full-width beats, incrementing burst
    localparam ar_cmd_t AR_CMD_RESET = '{
        id:     '0,
        addr:   '0,
        len:    '0,
        size:   size_t'($clog2(DATA_BITS / 8)),
        burst:  burst_t'(1),
        lock:   '0,
        cache:  '0,
        prot:   '0,
        qos:    '0,
        region: '0
    };

    typedef struct packed {
        logic       awvalid;
        axil_addr_t awaddr;
        logic       wvalid;
        axil_data_t wdata;
        axil_strb_t wstrb;
        logic       bready;
        logic       arvalid;
        axil_addr_t araddr;
        logic       rready;
    } axil_req_t;

    typedef struct packed {
        logic       awready;
        logic       wready;
        logic       bvalid;
        logic [1:0] bresp;
        logic       arready;
        logic       rvalid;
        axil_data_t rdata;
        logic [1:0] rresp;
    } axil_rsp_t;

endpackage

// ==== design/dma_read_regs.sv ====
`timescale 1ns/1ps

module dma_read_regs (
    input  logic                    s_axi4l,
    input  logic                    rst,
    input  dma_read_pkg::axil_req_t s_axil_req,
    output dma_read_pkg::axil_rsp_t s_axil_rsp,
    output dma_read_pkg::ar_cmd_t   cmd,
    output logic                    cmd_valid,
    input  logic                    cmd_ready,
    input  logic                    busy
);

    import dma_read_pkg::*;

    reg_idx_t   wr_idx;
    reg_idx_t   rd_idx;
    logic       wr_en;
    logic       rd_en;
    logic [1:0] status;
    axil_data_t wr_word;
    ar_cmd_t    cmd_q;
    logic       pending;
    logic       bvalid;
    logic       rvalid;
    axil_data_t rdata;

    // byte lanes under wstrb, the rest keeps the old value
    function automatic axil_data_t byte_merge(
        input axil_data_t org,
        input axil_data_t data,
        input axil_strb_t strb
    );
        axil_data_t merged;
        for (int i = 0; i < AXIL_STRB_BITS; i++) begin
            merged[8*i +: 8] = strb[i] ? data[8*i +: 8] : org[8*i +: 8];
        end
        return merged;
    endfunction

    function automatic axil_data_t reg_value(
        input reg_idx_t   idx,
        input ar_cmd_t    c,
        input logic [1:0] stat
    );
        axil_data_t value;
        case (idx)
            REG_CORE_ID:        value = CORE_ID;
            REG_CTL_STATUS:     value = axil_data_t'(stat);
            REG_PARAM_ARID:     value = axil_data_t'(c.id);
            REG_PARAM_ARADDR:   value = axil_data_t'(c.addr);
            REG_PARAM_ARLEN:    value = axil_data_t'(c.len);
            REG_PARAM_ARSIZE:   value = axil_data_t'(c.size);
            REG_PARAM_ARBURST:  value = axil_data_t'(c.burst);
            REG_PARAM_ARLOCK:   value = axil_data_t'(c.lock);
            REG_PARAM_ARCACHE:  value = axil_data_t'(c.cache);
            REG_PARAM_ARPROT:   value = axil_data_t'(c.prot);
            REG_PARAM_ARQOS:    value = axil_data_t'(c.qos);
            REG_PARAM_ARREGION: value = axil_data_t'(c.region);
            default:            value = '0;
        endcase
        return value;
    endfunction

    // ------------------------------------------------
    // decode
    // ------------------------------------------------
    assign wr_idx  = s_axil_req.awaddr[AXIL_ADDR_BITS-1:2];
    assign rd_idx  = s_axil_req.araddr[AXIL_ADDR_BITS-1:2];
    assign wr_en   = s_axil_req.awvalid & s_axil_req.wvalid & (~bvalid | s_axil_req.bready);
    assign rd_en   = s_axil_req.arvalid & (~rvalid | s_axil_req.rready);
    assign status  = {busy, pending};
    assign wr_word = byte_merge(reg_value(wr_idx, cmd_q, status),
                                s_axil_req.wdata, s_axil_req.wstrb);

    // ------------------------------------------------
    // parameter registers and pending flag
    // ------------------------------------------------
    always_ff @(posedge s_axi4l) begin
        if (rst) begin
            cmd_q   <= AR_CMD_RESET;
            pending <= 1'b0;
        end else begin
            if (cmd_ready) begin
                pending <= 1'b0;
            end
            if (wr_en) begin
                case (wr_idx)
                    REG_PARAM_ARID:     cmd_q.id     <= id_t'(wr_word);
                    REG_PARAM_ARADDR: begin
                        cmd_q.addr <= addr_t'(wr_word);
                        pending    <= 1'b1;
                    end
                    REG_PARAM_ARLEN:    cmd_q.len    <= len_t'(wr_word);
                    REG_PARAM_ARSIZE:   cmd_q.size   <= size_t'(wr_word);
                    REG_PARAM_ARBURST:  cmd_q.burst  <= burst_t'(wr_word);
                    REG_PARAM_ARLOCK:   cmd_q.lock   <= lock_t'(wr_word);
                    REG_PARAM_ARCACHE:  cmd_q.cache  <= cache_t'(wr_word);
                    REG_PARAM_ARPROT:   cmd_q.prot   <= prot_t'(wr_word);
                    REG_PARAM_ARQOS:    cmd_q.qos    <= qos_t'(wr_word);
                    REG_PARAM_ARREGION: cmd_q.region <= region_t'(wr_word);
                    default: ;
                endcase
            end
        end
    end

    assign cmd       = cmd_q;
    assign cmd_valid = pending;

    // ------------------------------------------------
    // response channels
    // ------------------------------------------------
    always_ff @(posedge s_axi4l) begin
        if (rst) begin
            bvalid <= 1'b0;
            rvalid <= 1'b0;
        end else begin
            if (wr_en) begin
                bvalid <= 1'b1;
            end else if (s_axil_req.bready) begin
                bvalid <= 1'b0;
            end
            if (rd_en) begin
                rvalid <= 1'b1;
            end else if (s_axil_req.rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge s_axi4l) begin
        if (rd_en) begin
            rdata <= reg_value(rd_idx, cmd_q, status);
        end
    end

    always_comb begin
        s_axil_rsp.awready = (~bvalid | s_axil_req.bready) & s_axil_req.wvalid;
        s_axil_rsp.wready  = (~bvalid | s_axil_req.bready) & s_axil_req.awvalid;
        s_axil_rsp.bvalid  = bvalid;
        s_axil_rsp.bresp   = 2'b00;
        s_axil_rsp.arready = ~rvalid | s_axil_req.rready;
        s_axil_rsp.rvalid  = rvalid;
        s_axil_rsp.rdata   = rdata;
        s_axil_rsp.rresp   = 2'b00;
    end

    // read data holds until the master takes it
    a_rvalid_held: assert property (
        @(posedge s_axi4l) disable iff (rst)
        rvalid && !s_axil_req.rready |=> rvalid && $stable(rdata)
    ) else $error("register read response dropped without rready");

endmodule

// ==== design/dma_read_stream.sv ====
`timescale 1ns/1ps

module dma_read_stream #(
    parameter int DATA_PTR_BITS = 4
) (
    input  logic                s_axi4l,
    input  logic                rst,
    input  dma_read_pkg::data_t rdata,
    input  logic                rvalid,
    output logic                rready,
    output dma_read_pkg::data_t tdata,
    output logic                tvalid,
    input  logic                tready,
    output logic                beat_done
);

    import dma_read_pkg::*;

    // read beats queue up here while the sink stalls
    dma_read_fifo #(
        .payload_t (data_t),
        .PTR_BITS  (DATA_PTR_BITS)
    ) data_fifo_i (
        .rst     (rst),
        .s_axi4l (s_axi4l),
        .s_data  (rdata),
        .s_valid (rvalid),
        .s_ready (rready),
        .m_data  (tdata),
        .m_valid (tvalid),
        .m_ready (tready)
    );

    // one pulse per beat taken by the sink
    assign beat_done = tvalid & tready;

    a_tdata_held: assert property (
        @(posedge s_axi4l) disable iff (rst)
        tvalid && !tready |=> tvalid && $stable(tdata)
    ) else $error("stream beat changed while stalled");

endmodule

// ==== design/dma_read_top.sv ====
`timescale 1ns/1ps

module dma_read_top #(
    parameter int CMD_PTR_BITS  = 2,
    parameter int DATA_PTR_BITS = 4
) (
    input  logic                    s_axi4l,
    input  logic                    rst,
    input  dma_read_pkg::axil_req_t s_axil_req,
    output dma_read_pkg::axil_rsp_t s_axil_rsp,
    output dma_read_pkg::ar_cmd_t   ar,
    output logic                    arvalid,
    input  logic                    arready,
    input  dma_read_pkg::data_t     rdata,
    input  logic                    rvalid,
    output logic                    rready,
    output dma_read_pkg::data_t     tdata,
    output logic                    tvalid,
    input  logic                    tready
);

    import dma_read_pkg::*;

    ar_cmd_t cmd;
    logic    cmd_valid;
    logic    cmd_ready;
    logic    busy;
    logic    beat_done;

    dma_read_regs regs_i (
        .s_axi4l    (s_axi4l),
        .rst        (rst),
        .s_axil_req (s_axil_req),
        .s_axil_rsp (s_axil_rsp),
        .cmd        (cmd),
        .cmd_valid  (cmd_valid),
        .cmd_ready  (cmd_ready),
        .busy       (busy)
    );

    dma_read_issue #(
        .CMD_PTR_BITS (CMD_PTR_BITS)
    ) issue_i (
        .s_axi4l   (s_axi4l),
        .rst       (rst),
        .cmd       (cmd),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .ar        (ar),
        .arvalid   (arvalid),
        .arready   (arready),
        .beat_done (beat_done),
        .busy      (busy)
    );

    dma_read_stream #(
        .DATA_PTR_BITS (DATA_PTR_BITS)
    ) stream_i (
        .s_axi4l   (s_axi4l),
        .rst       (rst),
        .rdata     (rdata),
        .rvalid    (rvalid),
        .rready    (rready),
        .tdata     (tdata),
        .tvalid    (tvalid),
        .tready    (tready),
        .beat_done (beat_done)
    );

endmodule

// ==== sources.f ====
design/dma_read_pkg.sv
design/dma_read_fifo.sv
design/dma_read_regs.sv
design/dma_read_issue.sv
design/dma_read_stream.sv
design/dma_read_top.sv
testbench/tb_dma_read_mem.sv
testbench/tb_dma_read.sv

// ==== testbench/tb_dma_read.sv ====
`timescale 1ns/1ps

module tb_dma_read;

    import dma_read_pkg::*;

    localparam logic [31:0] SEED_INIT     = 32'hcc17_1138;
    localparam axil_addr_t  CORE_ID_ADDR  = 32'h0000_0000;
    localparam axil_addr_t  STATUS_ADDR   = 32'h0000_0020;
    localparam axil_addr_t  UNMAPPED_ADDR = 32'h0000_0100;

    logic      s_axi4l;
    logic      rst;
    axil_req_t axil_req;
    axil_rsp_t axil_rsp;
    ar_cmd_t   ar;
    logic      arvalid;
    logic      arready;
    data_t     rdata;
    logic      rvalid;
    logic      rready;
    data_t     tdata;
    logic      tvalid;
    logic      tready;

    ar_cmd_t     exp_cmds [$];
    data_t       exp_beats [$];
    axil_data_t  shadow [10];
    string       test_name = "startup";
    int unsigned requested = 0;
    int unsigned cycles    = 0;
    logic        sink_stall = 1'b0;
    integer      sink_seed;

    dma_read_top #(
        .CMD_PTR_BITS  (2),
        .DATA_PTR_BITS (4)
    ) dut_i (
        .s_axi4l    (s_axi4l),
        .rst        (rst),
        .s_axil_req (axil_req),
        .s_axil_rsp (axil_rsp),
        .ar         (ar),
        .arvalid    (arvalid),
        .arready    (arready),
        .rdata      (rdata),
        .rvalid     (rvalid),
        .rready     (rready),
        .tdata      (tdata),
        .tvalid     (tvalid),
        .tready     (tready)
    );

    tb_dma_read_mem #(
        .SEED (SEED_INIT)
    ) mem_i (
        .s_axi4l (s_axi4l),
        .rst     (rst),
        .ar      (ar),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rvalid  (rvalid),
        .rready  (rready)
    );

    initial begin
        s_axi4l = 1'b0;
        forever #20 s_axi4l = ~s_axi4l;
    end

    // ------------------------------------------------
    // reporting and compares
    // ------------------------------------------------
    task automatic report_failure(input string reason);
        $display("%s", reason);
        $display("Some tests failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_reg(input string name, input axil_data_t exp, input axil_data_t act);
        if (exp !== act) begin
            report_failure($sformatf("MISMATCH %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_resp(input string name, input logic [1:0] exp, input logic [1:0] act);
        if (exp !== act) begin
            report_failure($sformatf("MISMATCH %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_cmd(input string name, input ar_cmd_t exp, input ar_cmd_t act);
        if (exp !== act) begin
            report_failure($sformatf("MISMATCH %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_beat(input string name, input data_t exp, input data_t act);
        if (exp !== act) begin
            report_failure($sformatf("MISMATCH %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    // ------------------------------------------------
    // reference model
    // ------------------------------------------------
    function automatic data_t beat_word(input ar_cmd_t c, input int i);
        addr_t baddr;
        baddr = c.addr + 32'(i * 8);
        return {baddr ^ 32'h5a5a_0000, baddr};
    endfunction

    function automatic axil_data_t merge_bytes(
        input axil_data_t old,
        input axil_data_t data,
        input axil_strb_t strb
    );
        axil_data_t res;
        for (int b = 0; b < 4; b++) begin
            res[8*b +: 8] = strb[b] ? data[8*b +: 8] : old[8*b +: 8];
        end
        return res;
    endfunction

    // field widths in register order
    function automatic axil_data_t field_mask(input int k);
        case (k)
            0, 2:    return 32'h0000_00ff;
            1:       return 32'hffff_ffff;
            3, 7:    return 32'h0000_0007;
            4:       return 32'h0000_0003;
            5:       return 32'h0000_0001;
            default: return 32'h0000_000f;
        endcase
    endfunction

    function automatic ar_cmd_t cmd_from_shadow();
        ar_cmd_t c;
        c.id     = id_t'(shadow[0]);
        c.addr   = addr_t'(shadow[1]);
        c.len    = len_t'(shadow[2]);
        c.size   = size_t'(shadow[3]);
        c.burst  = burst_t'(shadow[4]);
        c.lock   = lock_t'(shadow[5]);
        c.cache  = cache_t'(shadow[6]);
        c.prot   = prot_t'(shadow[7]);
        c.qos    = qos_t'(shadow[8]);
        c.region = region_t'(shadow[9]);
        return c;
    endfunction

    function automatic axil_addr_t param_addr(input int k);
        return axil_addr_t'((32'h10 + k) * 4);
    endfunction

    // ------------------------------------------------
    // register bus
    // ------------------------------------------------
    task automatic axil_write(input axil_addr_t addr, input axil_data_t data, input axil_strb_t strb);
        logic       done;
        logic [1:0] resp;
        axil_req.awvalid = 1'b1;
        axil_req.awaddr  = addr;
        axil_req.wvalid  = 1'b1;
        axil_req.wdata   = data;
        axil_req.wstrb   = strb;
        axil_req.bready  = 1'b1;
        done = 1'b0;
        while (!done) begin
            @(posedge s_axi4l);
            done = axil_rsp.awready & axil_rsp.wready;
            #1;
        end
        axil_req.awvalid = 1'b0;
        axil_req.wvalid  = 1'b0;
        done = 1'b0;
        while (!done) begin
            @(posedge s_axi4l);
            done = axil_rsp.bvalid;
            resp = axil_rsp.bresp;
            #1;
        end
        axil_req.bready = 1'b0;
        check_resp(test_name, 2'b00, resp);
    endtask

    task automatic axil_read(input axil_addr_t addr, output axil_data_t data);
        logic       done;
        logic [1:0] resp;
        axil_req.arvalid = 1'b1;
        axil_req.araddr  = addr;
        axil_req.rready  = 1'b1;
        done = 1'b0;
        while (!done) begin
            @(posedge s_axi4l);
            done = axil_rsp.arready;
            #1;
        end
        axil_req.arvalid = 1'b0;
        done = 1'b0;
        while (!done) begin
            @(posedge s_axi4l);
            done = axil_rsp.rvalid;
            data = axil_rsp.rdata;
            resp = axil_rsp.rresp;
            #1;
        end
        axil_req.rready = 1'b0;
        check_resp(test_name, 2'b00, resp);
    endtask

    task automatic read_check(input axil_addr_t addr, input axil_data_t exp);
        axil_data_t v;
        axil_read(addr, v);
        check_reg(test_name, exp, v);
    endtask

    task automatic check_params();
        for (int k = 0; k < 10; k++) begin
            read_check(param_addr(k), shadow[k]);
        end
    endtask

    // a full command queue leaves the last command pending
    task automatic wait_pending_clear();
        axil_data_t v;
        v = 32'h1;
        while (v[0]) begin
            axil_read(STATUS_ADDR, v);
        end
    endtask

    task automatic write_param(input int k, input axil_data_t data, input axil_strb_t strb);
        ar_cmd_t c;
        wait_pending_clear();
        shadow[k] = merge_bytes(shadow[k], data, strb) & field_mask(k);
        if (k == 1) begin
            c = cmd_from_shadow();
            exp_cmds.push_back(c);
            for (int i = 0; i <= int'(c.len); i++) begin
                exp_beats.push_back(beat_word(c, i));
            end
            requested += int'(c.len) + 1;
        end
        axil_write(param_addr(k), data, strb);
    endtask

    task automatic drain();
        while (exp_beats.size() != 0 || exp_cmds.size() != 0) begin
            @(posedge s_axi4l);
            #1;
        end
    endtask

    // ------------------------------------------------
    // monitors
    // ------------------------------------------------
    initial begin : ar_monitor
        ar_cmd_t c;
        forever begin
            @(posedge s_axi4l);
            if (!rst && arvalid && arready) begin
                if (exp_cmds.size() == 0) begin
                    report_failure("read address issued with no command expected");
                end else begin
                    c = exp_cmds.pop_front();
                    check_cmd(test_name, c, ar);
                end
            end
        end
    end

    initial begin : stream_monitor
        data_t w;
        sink_seed = SEED_INIT;
        tready    = 1'b0;
        forever begin
            @(posedge s_axi4l);
            if (!rst && tvalid && tready) begin
                if (exp_beats.size() == 0) begin
                    report_failure("stream beat delivered with none expected");
                end else begin
                    w = exp_beats.pop_front();
                    check_beat(test_name, w, tdata);
                end
            end
            #1;
            tready = sink_stall ? ($random(sink_seed) % 3 != 0) : 1'b1;
        end
    end

    initial begin : watchdog
        forever begin
            @(posedge s_axi4l);
            cycles++;
            if (cycles > 2000 + 200 * requested) begin
                report_failure($sformatf("timeout, run passed its limit of %0d cycles",
                                         2000 + 200 * requested));
            end
        end
    end

    // ------------------------------------------------
    // test sequence
    // ------------------------------------------------
    initial begin
        rst      = 1'b1;
        axil_req = '0;
        foreach (shadow[k]) begin
            shadow[k] = '0;
        end
        shadow[3] = 32'd3;
        shadow[4] = 32'd1;
        repeat (2) @(posedge s_axi4l);
        #1;
        rst = 1'b0;

        test_name = "reset_values";
        check_cmd(test_name, AR_CMD_RESET, cmd_from_shadow());
        read_check(CORE_ID_ADDR, CORE_ID);
        read_check(STATUS_ADDR, 32'h0);
        check_params();

        test_name = "strobe_merge";
        write_param(0, 32'hdead_beef, 4'b0001);
        write_param(0, 32'h1234_5600, 4'b0010);
        write_param(2, 32'h0000_0003, 4'b0001);
        write_param(6, 32'hffff_ffa5, 4'b0001);
        write_param(8, 32'hffff_ff00, 4'b1110);
        write_param(9, 32'h0000_00f6, 4'b0011);
        write_param(1, 32'h0000_1000, 4'b1111);
        write_param(1, 32'habcd_0040, 4'b1100);
        check_params();
        drain();

        test_name = "unmapped";
        read_check(UNMAPPED_ADDR, 32'h0);
        axil_write(UNMAPPED_ADDR, 32'hffff_ffff, 4'b1111);
        axil_write(STATUS_ADDR, 32'hffff_ffff, 4'b1111);
        read_check(UNMAPPED_ADDR, 32'h0);
        read_check(CORE_ID_ADDR, CORE_ID);
        read_check(STATUS_ADDR, 32'h0);
        check_params();

        test_name = "single_command";
        for (int k = 0; k < 10; k++) begin
            if (k != 1) begin
                write_param(k, 32'(k * 3 + 1), 4'b1111);
            end
        end
        write_param(1, 32'h0002_0000, 4'b1111);
        drain();
        read_check(STATUS_ADDR, 32'h0);

        test_name = "back_to_back";
        sink_stall = 1'b1;
        for (int n = 0; n < 6; n++) begin
            write_param(2, 32'((n * 5) % 8), 4'b0001);
            write_param(1, 32'h0004_0000 + 32'(n * 256), 4'b1111);
        end
        drain();
        read_check(STATUS_ADDR, 32'h0);

        $display("All tests passed");
        $finish;
    end

endmodule

// ==== testbench/tb_dma_read_mem.sv ====
`timescale 1ns/1ps

module tb_dma_read_mem #(
    parameter logic [31:0] SEED = 32'h0000_0001
) (
    input  logic                  s_axi4l,
    input  logic                  rst,
    input  dma_read_pkg::ar_cmd_t ar,
    input  logic                  arvalid,
    output logic                  arready,
    output dma_read_pkg::data_t   rdata,
    output logic                  rvalid,
    input  logic                  rready
);

    import dma_read_pkg::*;

    ar_cmd_t bursts [$];
    int      beat;
    integer  seed;

    // upper half scrambled so every address bit shows up twice
    function automatic data_t word_at(input addr_t a);
        return {a ^ 32'h5a5a_0000, a};
    endfunction

    initial begin
        seed    = SEED;
        beat    = 0;
        arready = 1'b0;
        rvalid  = 1'b0;
        rdata   = '0;
        forever begin
            @(posedge s_axi4l);
            if (rst) begin
                bursts.delete();
                beat = 0;
            end else begin
                if (arvalid && arready) begin
                    bursts.push_back(ar);
                end
                if (rvalid && rready) begin
                    if (beat == int'(bursts[0].len)) begin
                        void'(bursts.pop_front());
                        beat = 0;
                    end else begin
                        beat++;
                    end
                end
            end
            #1;
            // address channel stalls about one cycle in three
            arready = !rst && ($random(seed) % 3 != 0);
            rvalid  = bursts.size() != 0;
            if (rvalid) begin
                rdata = word_at(bursts[0].addr + 32'(beat * 8));
            end
        end
    end

endmodule
